//--- hw/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Rename slots offered to decode each cycle
`define NUM_ISSUE 4

// Oldest entries that can retire in one cycle
`define NUM_COMMIT 4

// Architectural registers, register 0 reads as zero
`define NUM_ARCH 32

// Commit queue entries, kept a power of two so the pointers wrap
`define CQ_DEPTH 32

`endif

//--- hw/renamePkg.sv
`default_nettype none

package renamePkg;

    // Top bit set means the tag names no physical register
    typedef logic [6:0] Tag;

    typedef logic [5:0] PhysIdx;

    typedef logic [4:0] ArchReg;

    // Encoding used for architectural register 0
    localparam Tag NO_TAG = 7'h40;

    // One renamed instruction waiting to retire
    typedef struct packed {
        ArchReg archReg;
        Tag newTag;
        Tag prevTag;
    } CommitEntry;

endpackage

`default_nettype wire

//--- hw/tagBuffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module tagBuffer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   mispr,
    input  wire logic [`NUM_ISSUE-1:0]  fire,
    input  wire logic                   retireValid[`NUM_COMMIT],
    input  wire renamePkg::Tag          retireNew[`NUM_COMMIT],
    input  wire renamePkg::Tag          retirePrev[`NUM_COMMIT],
    output renamePkg::PhysIdx           offerTag[`NUM_ISSUE],
    output logic                        offerValid[`NUM_ISSUE]
);
    import renamePkg::*;

    localparam int NUM_TAGS = 1 << $bits(PhysIdx);
    localparam int LEVELS = $clog2(NUM_TAGS);
    localparam int TAG_MSB = $bits(Tag) - 1;

    // Architectural registers start out mapped to the low tags
    localparam logic [NUM_TAGS-1:0] INIT_FREE =
        {{(NUM_TAGS - `NUM_ARCH){1'b1}}, {`NUM_ARCH{1'b0}}};

    // Speculative free vector also excludes tags sitting in an offer slot
    logic [NUM_TAGS-1:0] free;
    logic [NUM_TAGS-1:0] freeCom;
    logic [NUM_TAGS-1:0] freeNext;
    logic [NUM_TAGS-1:0] freeComNext;

    PhysIdx searchTag[`NUM_ISSUE];
    logic searchVld[`NUM_ISSUE];
    logic refill[`NUM_ISSUE];

    // Tree of lowest free indices, every node keeps up to NUM_ISSUE of them
    // with the valid ones packed towards slot 0
    for (genvar l = 0; l <= LEVELS; l++) begin : lvl
        for (genvar n = 0; n < (NUM_TAGS >> l); n++) begin : node
            PhysIdx idx[`NUM_ISSUE];
            logic vld[`NUM_ISSUE];

            if (l == 0) begin : leafCase
                always_comb begin
                    for (int j = 0; j < `NUM_ISSUE; j++) begin
                        idx[j] = PhysIdx'(n);
                        vld[j] = (j == 0) && free[n];
                    end
                end
            end else begin : mergeCase
                always_comb begin
                    int lowCnt;
                    lowCnt = 0;
                    for (int j = 0; j < `NUM_ISSUE; j++) begin
                        if (lvl[l-1].node[2*n].vld[j]) begin
                            lowCnt++;
                        end
                    end
                    // Lower half first, the upper half fills what is left
                    for (int j = 0; j < `NUM_ISSUE; j++) begin
                        idx[j] = lvl[l-1].node[2*n].idx[j];
                        vld[j] = lvl[l-1].node[2*n].vld[j];
                        for (int k = 0; k < `NUM_ISSUE; k++) begin
                            if (j >= lowCnt && k == j - lowCnt) begin
                                idx[j] = lvl[l-1].node[2*n+1].idx[k];
                                vld[j] = lvl[l-1].node[2*n+1].vld[k];
                            end
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            searchTag[j] = lvl[LEVELS].node[0].idx[j];
            searchVld[j] = lvl[LEVELS].node[0].vld[j];
        end
    end

    always_comb begin
        freeNext = free;
        freeComNext = freeCom;

        // Retire in age order so a tag displaced and reused in one group ends right
        for (int i = 0; i < `NUM_COMMIT; i++) begin
            if (retireValid[i] && !retireNew[i][TAG_MSB]) begin
                if (!retirePrev[i][TAG_MSB]) begin
                    freeNext[PhysIdx'(retirePrev[i])] = 1'b1;
                    freeComNext[PhysIdx'(retirePrev[i])] = 1'b1;
                end
                freeComNext[PhysIdx'(retireNew[i])] = 1'b0;
            end
        end

        // Slot j only ever takes the j-th search result
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            refill[j] = (!offerValid[j] || fire[j]) && searchVld[j];
            if (refill[j]) begin
                freeNext[searchTag[j]] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free <= INIT_FREE;
            freeCom <= INIT_FREE;
            for (int j = 0; j < `NUM_ISSUE; j++) begin
                offerValid[j] <= 1'b0;
            end
        end else begin
            freeCom <= freeComNext;
            if (mispr) begin
                // Offers return to the pool, refill waits a cycle
                free <= freeComNext;
                for (int j = 0; j < `NUM_ISSUE; j++) begin
                    offerValid[j] <= 1'b0;
                end
            end else begin
                free <= freeNext;
                for (int j = 0; j < `NUM_ISSUE; j++) begin
                    if (refill[j]) begin
                        offerValid[j] <= 1'b1;
                    end else if (fire[j]) begin
                        offerValid[j] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            if (refill[j] && !mispr) begin
                offerTag[j] <= searchTag[j];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/renameTable.sv
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module renameTable (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   mispr,
    input  wire logic [`NUM_ISSUE-1:0]  fire,
    input  wire renamePkg::ArchReg      dst[`NUM_ISSUE],
    input  wire renamePkg::ArchReg      srcA[`NUM_ISSUE],
    input  wire renamePkg::ArchReg      srcB[`NUM_ISSUE],
    input  wire renamePkg::Tag          newTag[`NUM_ISSUE],
    input  wire logic                   retireValid[`NUM_COMMIT],
    input  wire renamePkg::ArchReg      retireReg[`NUM_COMMIT],
    input  wire renamePkg::Tag          retireNew[`NUM_COMMIT],
    output renamePkg::Tag               srcTagA[`NUM_ISSUE],
    output renamePkg::Tag               srcTagB[`NUM_ISSUE],
    output renamePkg::Tag               prevTag[`NUM_ISSUE]
);
    import renamePkg::*;

    Tag specMap[`NUM_ARCH];
    Tag comMap[`NUM_ARCH];
    Tag comMapNext[`NUM_ARCH];

    // Register 0 is never written, its entry keeps NO_TAG from reset
    logic wr[`NUM_ISSUE];

    always_comb begin
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            wr[j] = fire[j] && (dst[j] != '0);
        end
    end

    // Lookups, a later slot sees what the earlier slots of its group wrote
    always_comb begin
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            srcTagA[j] = specMap[srcA[j]];
            srcTagB[j] = specMap[srcB[j]];
            prevTag[j] = specMap[dst[j]];
            for (int k = 0; k < j; k++) begin
                if (wr[k] && dst[k] == srcA[j]) begin
                    srcTagA[j] = newTag[k];
                end
                if (wr[k] && dst[k] == srcB[j]) begin
                    srcTagB[j] = newTag[k];
                end
                if (wr[k] && dst[k] == dst[j]) begin
                    prevTag[j] = newTag[k];
                end
            end
        end
    end

    // Committed map after this cycle's retirement
    always_comb begin
        comMapNext = comMap;
        for (int i = 0; i < `NUM_COMMIT; i++) begin
            if (retireValid[i] && retireReg[i] != '0) begin
                comMapNext[retireReg[i]] = retireNew[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_ARCH; r++) begin
                specMap[r] <= (r == 0) ? NO_TAG : Tag'(r);
                comMap[r] <= (r == 0) ? NO_TAG : Tag'(r);
            end
        end else begin
            comMap <= comMapNext;
            if (mispr) begin
                specMap <= comMapNext;
            end else begin
                // slot order, so the youngest writer of a register wins
                for (int j = 0; j < `NUM_ISSUE; j++) begin
                    if (wr[j]) begin
                        specMap[dst[j]] <= newTag[j];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/commitQueue.sv
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module commitQueue (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            mispr,
    input  wire logic [`NUM_ISSUE-1:0]           push,
    input  wire renamePkg::CommitEntry           pushEntry[`NUM_ISSUE],
    input  wire logic [$clog2(`NUM_COMMIT+1)-1:0] retireCount,
    output renamePkg::CommitEntry                headEntry[`NUM_COMMIT],
    output logic                                 retireValid[`NUM_COMMIT],
    output logic [$clog2(`CQ_DEPTH):0]           count,
    output logic [$clog2(`CQ_DEPTH):0]           room
);
    import renamePkg::*;

    localparam int PTR_W = $clog2(`CQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    CommitEntry mem[`CQ_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    // Write position of each pushed slot after compaction
    logic [PTR_W-1:0] slotPtr[`NUM_ISSUE];
    logic [CNT_W-1:0] pushCnt;

    always_comb begin
        pushCnt = '0;
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            slotPtr[j] = tail + pushCnt[PTR_W-1:0];
            if (push[j]) begin
                pushCnt = pushCnt + CNT_W'(1);
            end
        end
    end

    // Oldest entries, valid up to the requested retire count
    always_comb begin
        for (int i = 0; i < `NUM_COMMIT; i++) begin
            headEntry[i] = mem[head + PTR_W'(i)];
            retireValid[i] = int'(retireCount) > i;
        end
    end

    assign room = CNT_W'(`CQ_DEPTH) - count;

    always_ff @(posedge clk) begin
        if (rst || mispr) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            head <= head + PTR_W'(retireCount);
            tail <= tail + pushCnt[PTR_W-1:0];
            count <= count + pushCnt - CNT_W'(retireCount);
        end
    end

    always_ff @(posedge clk) begin
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            if (push[j]) begin
                mem[slotPtr[j]] <= pushEntry[j];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/renameUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module renameUnit (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            decValid[`NUM_ISSUE],
    input  wire renamePkg::ArchReg               decDst[`NUM_ISSUE],
    input  wire renamePkg::ArchReg               decSrcA[`NUM_ISSUE],
    input  wire renamePkg::ArchReg               decSrcB[`NUM_ISSUE],
    input  wire logic [$clog2(`NUM_COMMIT+1)-1:0] retireCount,
    input  wire logic                            mispr,
    output logic                                 stall,
    output logic                                 renValid[`NUM_ISSUE],
    output renamePkg::Tag                        renDst[`NUM_ISSUE],
    output renamePkg::Tag                        renSrcA[`NUM_ISSUE],
    output renamePkg::Tag                        renSrcB[`NUM_ISSUE],
    output renamePkg::Tag                        renPrev[`NUM_ISSUE],
    output logic [$clog2(`CQ_DEPTH):0]           cqCount
);
    import renamePkg::*;

    PhysIdx offerTag[`NUM_ISSUE];
    logic offerValid[`NUM_ISSUE];

    logic [`NUM_ISSUE-1:0] push;
    logic [`NUM_ISSUE-1:0] fire;
    CommitEntry pushEntry[`NUM_ISSUE];

    CommitEntry headEntry[`NUM_COMMIT];
    logic retireValid[`NUM_COMMIT];
    ArchReg retireReg[`NUM_COMMIT];
    Tag retireNew[`NUM_COMMIT];
    Tag retirePrev[`NUM_COMMIT];

    logic [$clog2(`CQ_DEPTH):0] room;
    logic [$clog2(`CQ_DEPTH):0] needCnt;
    logic noTag;

    // High in the cycle after reset or a mispredict
    logic settle;

    always_ff @(posedge clk) begin
        if (rst) begin
            settle <= 1'b1;
        end else begin
            settle <= mispr;
        end
    end

    always_comb begin
        needCnt = '0;
        noTag = 1'b0;
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            if (decValid[j]) begin
                needCnt = needCnt + ($clog2(`CQ_DEPTH) + 1)'(1);
            end
            if (decValid[j] && decDst[j] != '0 && !offerValid[j]) begin
                noTag = 1'b1;
            end
        end
    end

    // Whole group renames or none of it
    assign stall = settle || noTag || (needCnt > room);

    always_comb begin
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            push[j] = decValid[j] && !stall;
            fire[j] = push[j] && (decDst[j] != '0);
            renValid[j] = push[j];
            // Only slots writing a register use their offer
            renDst[j] = (decDst[j] != '0) ? {1'b0, offerTag[j]} : NO_TAG;
            pushEntry[j].archReg = decDst[j];
            pushEntry[j].newTag = renDst[j];
            pushEntry[j].prevTag = renPrev[j];
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_COMMIT; i++) begin
            retireReg[i] = headEntry[i].archReg;
            retireNew[i] = headEntry[i].newTag;
            retirePrev[i] = headEntry[i].prevTag;
        end
    end

    tagBuffer tagBuf (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .fire(fire),
        .retireValid(retireValid),
        .retireNew(retireNew),
        .retirePrev(retirePrev),
        .offerTag(offerTag),
        .offerValid(offerValid)
    );

    renameTable rat (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .fire(fire),
        .dst(decDst),
        .srcA(decSrcA),
        .srcB(decSrcB),
        .newTag(renDst),
        .retireValid(retireValid),
        .retireReg(retireReg),
        .retireNew(retireNew),
        .srcTagA(renSrcA),
        .srcTagB(renSrcB),
        .prevTag(renPrev)
    );

    commitQueue cq (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .push(push),
        .pushEntry(pushEntry),
        .retireCount(retireCount),
        .headEntry(headEntry),
        .retireValid(retireValid),
        .count(cqCount),
        .room(room)
    );

endmodule

`default_nettype wire

//--- verif/renameTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rename_macros.svh"

module renameTb;
    import renamePkg::*;

    localparam int NUM_TAGS = 64;
    localparam int NUM_CYCLES = 3000;

    logic clk;
    logic rst;
    logic decValid[`NUM_ISSUE];
    ArchReg decDst[`NUM_ISSUE];
    ArchReg decSrcA[`NUM_ISSUE];
    ArchReg decSrcB[`NUM_ISSUE];
    logic [2:0] retireCount;
    logic mispr;
    logic stall;
    logic renValid[`NUM_ISSUE];
    Tag renDst[`NUM_ISSUE];
    Tag renSrcA[`NUM_ISSUE];
    Tag renSrcB[`NUM_ISSUE];
    Tag renPrev[`NUM_ISSUE];
    logic [5:0] cqCount;

    integer seed;
    int stallCount = 0;
    int misprCount = 0;

    // Reference state
    Tag mSpec[`NUM_ARCH];
    Tag mCom[`NUM_ARCH];
    logic [NUM_TAGS-1:0] mFree;
    logic [NUM_TAGS-1:0] mFreeCom;
    logic mOffValid[`NUM_ISSUE];
    PhysIdx mOffTag[`NUM_ISSUE];
    logic mSettle;
    CommitEntry mQueue[$];

    // Expected outputs of the current cycle
    logic expStall;
    logic expBlocked;
    logic [5:0] expCount;
    logic expValid[`NUM_ISSUE];
    Tag expDst[`NUM_ISSUE];
    Tag expSrcA[`NUM_ISSUE];
    Tag expSrcB[`NUM_ISSUE];
    Tag expPrev[`NUM_ISSUE];

    renameUnit UUT (
        .clk(clk),
        .rst(rst),
        .decValid(decValid),
        .decDst(decDst),
        .decSrcA(decSrcA),
        .decSrcB(decSrcB),
        .retireCount(retireCount),
        .mispr(mispr),
        .stall(stall),
        .renValid(renValid),
        .renDst(renDst),
        .renSrcA(renSrcA),
        .renSrcB(renSrcB),
        .renPrev(renPrev),
        .cqCount(cqCount)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input string sig, input logic [31:0] expVal,
                                  input logic [31:0] gotVal);
        failRun($sformatf("MISMATCH at %0t: %s expected %0h got %0h",
                          $time, sig, expVal, gotVal));
    endtask

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic void resetModel();
        for (int r = 0; r < `NUM_ARCH; r++) begin
            mSpec[r] = (r == 0) ? NO_TAG : Tag'(r);
            mCom[r] = mSpec[r];
        end
        mFree = {{(NUM_TAGS - `NUM_ARCH){1'b1}}, {`NUM_ARCH{1'b0}}};
        mFreeCom = mFree;
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            mOffValid[j] = 1'b0;
            mOffTag[j] = '0;
        end
        mSettle = 1'b1;
        mQueue.delete();
    endfunction

    // Expected outputs for this cycle, then the state after the coming edge
    function automatic void predictModel();
        Tag tmpMap[`NUM_ARCH];
        PhysIdx pick[`NUM_ISSUE];
        logic fired[`NUM_ISSUE];
        CommitEntry e;
        int nPick;
        int needCnt;
        logic noTag;
        needCnt = 0;
        noTag = 1'b0;
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            if (decValid[j]) begin
                needCnt++;
                if (decDst[j] != '0 && !mOffValid[j]) begin
                    noTag = 1'b1;
                end
            end
        end
        expCount = 6'(mQueue.size());
        expBlocked = noTag || (needCnt > `CQ_DEPTH - mQueue.size());
        expStall = mSettle || expBlocked;

        // Walk the group in order so later slots see earlier writes
        tmpMap = mSpec;
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            fired[j] = decValid[j] && !expStall;
            expValid[j] = fired[j];
            expDst[j] = (decDst[j] != '0) ? {1'b0, mOffTag[j]} : NO_TAG;
            expSrcA[j] = tmpMap[decSrcA[j]];
            expSrcB[j] = tmpMap[decSrcB[j]];
            expPrev[j] = tmpMap[decDst[j]];
            if (fired[j] && decDst[j] != '0) begin
                tmpMap[decDst[j]] = expDst[j];
            end
        end

        // Lowest free tags as seen before this cycle's retirement
        nPick = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (mFree[t] && nPick < `NUM_ISSUE) begin
                pick[nPick] = PhysIdx'(t);
                nPick++;
            end
        end

        for (int i = 0; i < int'(retireCount); i++) begin
            e = mQueue.pop_front();
            if (!e.newTag[6]) begin
                if (!e.prevTag[6]) begin
                    mFree[e.prevTag[5:0]] = 1'b1;
                    mFreeCom[e.prevTag[5:0]] = 1'b1;
                end
                mFreeCom[e.newTag[5:0]] = 1'b0;
                mCom[e.archReg] = e.newTag;
            end
        end

        if (mispr) begin
            mSpec = mCom;
            mFree = mFreeCom;
            for (int j = 0; j < `NUM_ISSUE; j++) begin
                mOffValid[j] = 1'b0;
            end
            mSettle = 1'b1;
            mQueue.delete();
        end else begin
            mSpec = tmpMap;
            for (int j = 0; j < `NUM_ISSUE; j++) begin
                if (fired[j]) begin
                    e.archReg = decDst[j];
                    e.newTag = expDst[j];
                    e.prevTag = expPrev[j];
                    mQueue.push_back(e);
                end
                // An offer is used up only by a slot that writes a register
                if ((!mOffValid[j] || (fired[j] && decDst[j] != '0)) && j < nPick) begin
                    mOffValid[j] = 1'b1;
                    mOffTag[j] = pick[j];
                    mFree[pick[j]] = 1'b0;
                end else if (fired[j] && decDst[j] != '0) begin
                    mOffValid[j] = 1'b0;
                end
            end
            mSettle = 1'b0;
        end
    endfunction

    task automatic checkOutputs();
        assert (stall === expStall)
            else reportMismatch("stall", 32'(expStall), 32'(stall));
        assert (cqCount === expCount)
            else reportMismatch("cqCount", 32'(expCount), 32'(cqCount));
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            assert (renValid[j] === expValid[j])
                else reportMismatch($sformatf("renValid[%0d]", j), 32'(expValid[j]),
                                    32'(renValid[j]));
            if (expValid[j]) begin
                assert (renDst[j] === expDst[j])
                    else reportMismatch($sformatf("renDst[%0d]", j), 32'(expDst[j]),
                                        32'(renDst[j]));
                assert (renSrcA[j] === expSrcA[j])
                    else reportMismatch($sformatf("renSrcA[%0d]", j), 32'(expSrcA[j]),
                                        32'(renSrcA[j]));
                assert (renSrcB[j] === expSrcB[j])
                    else reportMismatch($sformatf("renSrcB[%0d]", j), 32'(expSrcB[j]),
                                        32'(renSrcB[j]));
                assert (renPrev[j] === expPrev[j])
                    else reportMismatch($sformatf("renPrev[%0d]", j), 32'(expPrev[j]),
                                        32'(renPrev[j]));
            end
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            resetModel();
        end else begin
            predictModel();
            // Only stalls from running out of tags or queue room
            if (expBlocked) begin
                stallCount++;
            end
            if (mispr) begin
                misprCount++;
            end
            checkOutputs();
        end
    end

    task automatic clearGroup();
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            decValid[j] = 1'b0;
            decDst[j] = '0;
            decSrcA[j] = '0;
            decSrcB[j] = '0;
        end
    endtask

    task automatic driveCycle(input int cycle);
        int avail;
        logic starve;
        // Every third phase retires nothing, so tags and queue run dry
        starve = ((cycle / 250) % 3) == 1;
        for (int j = 0; j < `NUM_ISSUE; j++) begin
            decValid[j] = randBelow(4) != 0;
            decDst[j] = (randBelow(8) == 0) ? '0 : ArchReg'(randBelow(32));
            decSrcA[j] = ArchReg'(randBelow(32));
            decSrcB[j] = ArchReg'(randBelow(32));
            if (cycle == 0) begin
                // First group reads what the slot below it writes
                decValid[j] = 1'b1;
                decDst[j] = ArchReg'(j + 1);
                decSrcA[j] = ArchReg'(j);
                decSrcB[j] = ArchReg'(j + 10);
            end
        end
        avail = mQueue.size();
        if (avail > `NUM_COMMIT) begin
            avail = `NUM_COMMIT;
        end
        retireCount = starve ? 3'd0 : 3'(randBelow(avail + 1));
        mispr = !starve && cycle != 0 && randBelow(40) == 0;
    endtask

    task automatic waitStallLow(input int limit);
        int waited;
        waited = 0;
        while (stall !== 1'b0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > limit) begin
                failRun("stall did not fall after reset");
            end
        end
    endtask

    task automatic drainQueue(input int limit);
        int waited;
        int avail;
        waited = 0;
        clearGroup();
        mispr = 1'b0;
        while (cqCount != 0) begin
            avail = mQueue.size();
            retireCount = 3'((avail > `NUM_COMMIT) ? `NUM_COMMIT : avail);
            @(posedge clk);
            #1;
            waited++;
            if (waited > limit) begin
                failRun("commit queue did not drain");
            end
        end
        retireCount = '0;
    endtask

    initial begin
        seed = 83;
        rst = 1'b1;
        mispr = 1'b0;
        retireCount = '0;
        clearGroup();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        waitStallLow(10);
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            driveCycle(cycle);
            @(posedge clk);
            #1;
        end
        drainQueue(20);
        @(posedge clk);
        #1;
        if (stallCount == 0 || misprCount == 0) begin
            failRun("run never ran out of tags or queue room, or never saw a mispredict");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/renamePkg.sv
hw/tagBuffer.sv
hw/renameTable.sv
hw/commitQueue.sv
hw/renameUnit.sv
verif/renameTb.sv

//--- Makefile
TOP = renameTb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
